//--- tb/rv_core_golden.txt
# I <addr> <instr>        program word
# W <addr> <data> <strb>  expected write in bus order, H <halted> expected halt at the end
I 00000000 20000513 # addi x10,x0,512
I 00000004 02500093 # addi x1,x0,37
I 00000008 ffb00113 # addi x2,x0,-5
I 0000000c 002081b3 # add x3,x1,x2
I 00000010 00352023 # sw x3,0(x10)
I 00000014 40208233 # sub x4,x1,x2
I 00000018 00452223 # sw x4,4(x10)
I 0000001c 0020f2b3 # and x5,x1,x2
I 00000020 00552423 # sw x5,8(x10)
I 00000024 0020e333 # or x6,x1,x2
I 00000028 00652623 # sw x6,12(x10)
I 0000002c 0020c3b3 # xor x7,x1,x2
I 00000030 00752823 # sw x7,16(x10)
I 00000034 00112433 # slt x8,x2,x1
I 00000038 00852a23 # sw x8,20(x10)
I 0000003c 123454b7 # lui x9,0x12345
I 00000040 00952c23 # sw x9,24(x10)
I 00000044 00001597 # auipc x11,1
I 00000048 00b52e23 # sw x11,28(x10)
I 0000004c 001502a3 # sb x1,5(x10)
I 00000050 00452603 # lw x12,4(x10)
I 00000054 02c52023 # sw x12,32(x10)
I 00000058 00208463 # beq x1,x2,8 not taken
I 0000005c 02152223 # sw x1,36(x10)
I 00000060 00209463 # bne x1,x2,8 taken
I 00000064 02252423 # sw x2,40(x10) skipped
I 00000068 008006ef # jal x13,8
I 0000006c 02252623 # sw x2,44(x10) skipped
I 00000070 02d52823 # sw x13,48(x10)
I 00000074 07100793 # addi x15,x0,0x71
I 00000078 01078767 # jalr x14,16(x15) to 0x80
I 0000007c 02252a23 # sw x2,52(x10) skipped
I 00000080 02e52c23 # sw x14,56(x10)
I 00000084 00100073 # ebreak
W 00000200 00000020 f
W 00000204 0000002a f
W 00000208 00000021 f
W 0000020c ffffffff f
W 00000210 ffffffde f
W 00000214 00000001 f
W 00000218 12345000 f
W 0000021c 00001044 f
W 00000204 25252525 2
W 00000220 0000252a f
W 00000224 00000025 f
W 00000230 0000006c f
W 00000238 0000007c f
H 1

//--- vlog.f
+incdir+src
src/rv_pkg.sv
src/rv_fetch.sv
src/rv_stage_reg.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_lsu.sv
src/rv_bus_arbiter.sv
src/rv_core.sv
tb/rv_core_props.sv
tb/rv_core_tb.sv

//--- tb/rv_core_tb.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module rv_core_tb import rv_pkg::*; ();
  localparam int clk_half_ns      = 10;
  localparam int reset_cycles     = 8;
  localparam int cycles_per_word  = 40;
  localparam int post_halt_cycles = 20;
  localparam int mem_words        = 256;

  logic        clk;
  logic        rst;
  bus_rd_req_t rd_req_o;
  logic        rd_req_valid_o;
  logic        rd_req_ready_i;
  bus_rd_rsp_t rd_rsp_i;
  logic        rd_rsp_valid_i;
  logic        rd_rsp_ready_o;
  bus_wr_req_t wr_req_o;
  logic        wr_req_valid_o;
  logic        wr_req_ready_i;
  bus_wr_rsp_t wr_rsp_i;
  logic        wr_rsp_valid_i;
  logic        wr_rsp_ready_o;
  logic        halt_o;

  logic [31:0] mem [mem_words];
  logic [31:0] lfsr_q = 32'hb65eace9;
  bus_wr_req_t exp_wr [$];
  logic        exp_halt;
  logic        loaded = 1'b0;
  int          exp_total;
  int          prog_words;
  int          wr_count;
  int          errors;
  int          checks;

  rv_core UUT (.*);

  initial begin
    clk = 1'b0;
    forever #clk_half_ns clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int stall_cycles();
    int d;
    lfsr_q = lfsr_step(lfsr_q);
    d = lfsr_q[0];
    lfsr_q = lfsr_step(lfsr_q);
    d = 2 * d + lfsr_q[0];
    return d;
  endfunction

  task automatic load_golden();
    int          fd;
    int          n;
    string       line;
    byte         kind;
    logic [31:0] a, b, c;
    bus_wr_req_t w;
    fd = $fopen("tb/rv_core_golden.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Cannot open tb/rv_core_golden.txt");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0 && line[0] != "#") begin
          n = $sscanf(line, "%c %h %h %h", kind, a, b, c);
          case (kind)
            "I": begin
              mem[a[9:2]] = b;
              prog_words++;
            end
            "W": begin
              w.addr = a;
              w.data = b;
              w.strb = c[3:0];
              exp_wr.push_back(w);
            end
            "H": exp_halt = a[0];
            default: ;
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s expected %b got %b", $time, name, exp, got);
    end
  endtask

  task automatic check_idle_levels();
    check_level("rd_req_valid_o", rd_req_valid_o, 1'b0);
    check_level("wr_req_valid_o", wr_req_valid_o, 1'b0);
    check_level("halt_o", halt_o, 1'b0);
    check_level("rd_rsp_ready_o", rd_rsp_ready_o, 1'b1);
    check_level("wr_rsp_ready_o", wr_rsp_ready_o, 1'b1);
  endtask

  task automatic check_rd(input bus_rd_req_t got, input bus_rd_req_t exp);
    checks++;
    if (got.addr !== exp.addr) begin
      errors++;
      $display("FAILED at %0t ns: rd_req_o.addr expected %h got %h", $time, exp.addr, got.addr);
    end
  endtask

  task automatic check_wr(input bus_wr_req_t got);
    bus_wr_req_t exp;
    wr_count++;
    checks++;
    if (exp_wr.size() == 0) begin
      errors++;
      $display("Write %0d to %h at %0t ns is beyond the expected list",
               wr_count, got.addr, $time);
    end else begin
      exp = exp_wr.pop_front();
      if (got.addr !== exp.addr) begin
        errors++;
        $display("FAILED at %0t ns: wr_req_o.addr expected %h got %h",
                 $time, exp.addr, got.addr);
      end
      if (got.data !== exp.data) begin
        errors++;
        $display("FAILED at %0t ns: wr_req_o.data expected %h got %h",
                 $time, exp.data, got.data);
      end
      if (got.strb !== exp.strb) begin
        errors++;
        $display("FAILED at %0t ns: wr_req_o.strb expected %h got %h",
                 $time, exp.strb, got.strb);
      end
    end
  endtask

  task automatic check_halt(input logic got_halt, input int got_count);
    checks++;
    if (got_halt !== exp_halt) begin
      errors++;
      $display("FAILED at %0t ns: halt_o expected %b got %b", $time, exp_halt, got_halt);
    end
    if (got_count != exp_total) begin
      errors++;
      $display("FAILED at %0t ns: write count expected %0d got %0d",
               $time, exp_total, got_count);
    end
  endtask

  task automatic apply_write(input bus_wr_req_t req);
    for (int b = 0; b < 4; b++) begin
      if (req.strb[b]) begin
        mem[req.addr[9:2]][8*b +: 8] = req.data[8*b +: 8];
      end
    end
  endtask

  // Read slave, one transfer at a time
  initial begin : read_slave
    logic [31:0] addr;
    bus_rd_rsp_t rsp;
    int          d;
    forever begin
      @(posedge clk);
      if (!rst && rd_req_valid_o) begin
        d = stall_cycles();
        repeat (d) @(posedge clk);
        addr = rd_req_o.addr;
        rd_req_ready_i <= 1'b1;
        @(posedge clk);
        rd_req_ready_i <= 1'b0;
        d = stall_cycles();
        repeat (d) @(posedge clk);
        rsp.data = mem[addr[9:2]];
        rsp.resp = 2'b00;
        rd_rsp_i       <= rsp;
        rd_rsp_valid_i <= 1'b1;
        do @(posedge clk); while (!rd_rsp_ready_o);
        rd_rsp_valid_i <= 1'b0;
      end
    end
  end

  initial begin : write_slave
    bus_wr_req_t req;
    int          d;
    forever begin
      @(posedge clk);
      if (!rst && wr_req_valid_o) begin
        d = stall_cycles();
        repeat (d) @(posedge clk);
        wr_req_ready_i <= 1'b1;
        @(posedge clk);
        req = wr_req_o;
        wr_req_ready_i <= 1'b0;
        apply_write(req);
        check_wr(req);
        d = stall_cycles();
        repeat (d) @(posedge clk);
        wr_rsp_i       <= '0;
        wr_rsp_valid_i <= 1'b1;
        do @(posedge clk); while (!wr_rsp_ready_o);
        wr_rsp_valid_i <= 1'b0;
      end
    end
  end

  initial begin : watchdog
    int limit;
    wait (loaded);
    limit = prog_words * cycles_per_word + reset_cycles + post_halt_cycles;
    repeat (limit) @(posedge clk);
    $display("Timeout: core did not halt within %0d cycles", limit);
    $display("Errors: %0d, checks: %0d", errors, checks);
    $display("Result: FAILED");
    $finish;
  end

  initial begin : main_seq
    bus_rd_req_t first_rd;
    first_rd.addr  = `RV_PC_RESET;
    rst            = 1'b1;
    rd_req_ready_i = 1'b0;
    rd_rsp_i       = '0;
    rd_rsp_valid_i = 1'b0;
    wr_req_ready_i = 1'b0;
    wr_rsp_i       = '0;
    wr_rsp_valid_i = 1'b0;
    exp_halt       = 1'b0;
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = 32'ha5a5_0000 ^ (i << 2);
    end
    load_golden();
    exp_total = exp_wr.size();
    loaded = 1'b1;

    // First edge applies reset, the rest see reset values
    @(posedge clk);
    repeat (reset_cycles - 1) begin
      @(posedge clk);
      check_idle_levels();
    end
    rst <= 1'b0;
    @(posedge clk);
    check_idle_levels();

    while (!rd_req_valid_o) @(posedge clk);
    check_rd(rd_req_o, first_rd);

    while (!halt_o) @(posedge clk);
    repeat (post_halt_cycles) begin
      @(posedge clk);
      check_level("rd_req_valid_o", rd_req_valid_o, 1'b0);
      check_level("wr_req_valid_o", wr_req_valid_o, 1'b0);
    end
    check_halt(halt_o, wr_count);

    $display("Errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- tb/rv_core_props.sv
`timescale 1ns/1ns

module rv_core_props import rv_pkg::*; (
  input logic        clk,
  input logic        rst,
  input bus_rd_req_t rd_req_i,
  input logic        rd_req_valid_i,
  input logic        rd_req_ready_i,
  input bus_wr_req_t wr_req_i,
  input logic        wr_req_valid_i,
  input logic        wr_req_ready_i,
  input logic        halt_i
);

  // Pending requests keep valid and payload until accepted
  rd_req_hold: assert property (@(posedge clk) disable iff (rst)
    rd_req_valid_i && !rd_req_ready_i |=> rd_req_valid_i && $stable(rd_req_i))
    else $error("read request dropped or changed while stalled");

  wr_req_hold: assert property (@(posedge clk) disable iff (rst)
    wr_req_valid_i && !wr_req_ready_i |=> wr_req_valid_i && $stable(wr_req_i))
    else $error("write request dropped or changed while stalled");

  halt_sticky: assert property (@(posedge clk) disable iff (rst)
    halt_i |=> halt_i)
    else $error("halt_o fell without reset");

  quiet_after_halt: assert property (@(posedge clk) disable iff (rst)
    halt_i |=> !$rose(rd_req_valid_i) && !$rose(wr_req_valid_i))
    else $error("bus request raised after halt");

  // Checked once reset has taken effect
  quiet_in_reset: assert property (@(posedge clk)
    rst ##1 rst |-> !rd_req_valid_i && !wr_req_valid_i && !halt_i)
    else $error("request valid or halt high during reset");

endmodule

bind rv_core rv_core_props u_props (
  .clk(clk),
  .rst(rst),
  .rd_req_i(rd_req_o),
  .rd_req_valid_i(rd_req_valid_o),
  .rd_req_ready_i(rd_req_ready_i),
  .wr_req_i(wr_req_o),
  .wr_req_valid_i(wr_req_valid_o),
  .wr_req_ready_i(wr_req_ready_i),
  .halt_i(halt_o)
);

//--- src/rv_core.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module rv_core import rv_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  output bus_rd_req_t rd_req_o,
  output logic        rd_req_valid_o,
  input  logic        rd_req_ready_i,
  input  bus_rd_rsp_t rd_rsp_i,
  input  logic        rd_rsp_valid_i,
  output logic        rd_rsp_ready_o,
  output bus_wr_req_t wr_req_o,
  output logic        wr_req_valid_o,
  input  logic        wr_req_ready_i,
  input  bus_wr_rsp_t wr_rsp_i,
  input  logic        wr_rsp_valid_i,
  output logic        wr_rsp_ready_o,
  output logic        halt_o
);
  fetch_pkt_t       f_pkt, d_pkt;
  logic             f_valid, f_ready, d_valid, d_ready;
  exec_pkt_t        x_pkt_in, x_pkt;
  logic             x_valid_in, x_ready_in, x_valid, x_ready;
  logic [4:0]       rs1, rs2, rd;
  logic [`XLEN-1:0] rs1_data, rs2_data, wdata, next_pc;
  logic             we, retire;
  mem_op_e          mem_op;
  logic [`XLEN-1:0] mem_addr, mem_wdata, mem_rdata;
  logic             mem_valid, mem_done;
  bus_rd_req_t      f_rd_req, l_rd_req;
  bus_rd_rsp_t      f_rd_rsp, l_rd_rsp;
  logic             f_rd_req_valid, f_rd_req_ready, f_rd_rsp_valid;
  logic             l_rd_req_valid, l_rd_req_ready, l_rd_rsp_valid;
  bus_wr_req_t      l_wr_req;
  logic             l_wr_req_valid, l_wr_req_ready, l_wr_rsp_valid;

  rv_fetch u_fetch (
    .clk(clk), .rst(rst),
    .retire_i(retire), .next_pc_i(next_pc), .halt_i(halt_o),
    .rd_req_o(f_rd_req), .rd_req_valid_o(f_rd_req_valid), .rd_req_ready_i(f_rd_req_ready),
    .rd_rsp_i(f_rd_rsp), .rd_rsp_valid_i(f_rd_rsp_valid),
    .pkt_o(f_pkt), .pkt_valid_o(f_valid), .pkt_ready_i(f_ready)
  );

  rv_stage_reg #(.T(fetch_pkt_t)) u_fd_reg (
    .clk(clk), .rst(rst),
    .in_i(f_pkt), .in_valid_i(f_valid), .in_ready_o(f_ready),
    .out_o(d_pkt), .out_valid_o(d_valid), .out_ready_i(d_ready)
  );

  rv_decode u_decode (
    .pkt_i(d_pkt), .pkt_valid_i(d_valid), .pkt_ready_o(d_ready),
    .rs1_o(rs1), .rs2_o(rs2), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .exec_o(x_pkt_in), .exec_valid_o(x_valid_in), .exec_ready_i(x_ready_in)
  );

  rv_regfile u_regfile (
    .clk(clk), .rst(rst),
    .rs1_i(rs1), .rs2_i(rs2), .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
    .we_i(we), .rd_i(rd), .wdata_i(wdata)
  );

  rv_stage_reg #(.T(exec_pkt_t)) u_dx_reg (
    .clk(clk), .rst(rst),
    .in_i(x_pkt_in), .in_valid_i(x_valid_in), .in_ready_o(x_ready_in),
    .out_o(x_pkt), .out_valid_o(x_valid), .out_ready_i(x_ready)
  );

  rv_execute u_execute (
    .clk(clk), .rst(rst),
    .exec_i(x_pkt), .exec_valid_i(x_valid), .exec_ready_o(x_ready),
    .mem_op_o(mem_op), .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata),
    .mem_valid_o(mem_valid), .mem_done_i(mem_done), .mem_rdata_i(mem_rdata),
    .we_o(we), .rd_o(rd), .wdata_o(wdata),
    .retire_o(retire), .next_pc_o(next_pc), .halt_o(halt_o)
  );

  rv_lsu u_lsu (
    .clk(clk), .rst(rst),
    .mem_op_i(mem_op), .mem_addr_i(mem_addr), .mem_wdata_i(mem_wdata),
    .mem_valid_i(mem_valid), .mem_done_o(mem_done), .mem_rdata_o(mem_rdata),
    .rd_req_o(l_rd_req), .rd_req_valid_o(l_rd_req_valid), .rd_req_ready_i(l_rd_req_ready),
    .rd_rsp_i(l_rd_rsp), .rd_rsp_valid_i(l_rd_rsp_valid),
    .wr_req_o(l_wr_req), .wr_req_valid_o(l_wr_req_valid), .wr_req_ready_i(l_wr_req_ready),
    .wr_rsp_valid_i(l_wr_rsp_valid)
  );

  rv_bus_arbiter u_arbiter (
    .clk(clk), .rst(rst),
    .f_rd_req_i(f_rd_req), .f_rd_req_valid_i(f_rd_req_valid),
    .f_rd_req_ready_o(f_rd_req_ready), .f_rd_rsp_o(f_rd_rsp),
    .f_rd_rsp_valid_o(f_rd_rsp_valid),
    .l_rd_req_i(l_rd_req), .l_rd_req_valid_i(l_rd_req_valid),
    .l_rd_req_ready_o(l_rd_req_ready), .l_rd_rsp_o(l_rd_rsp),
    .l_rd_rsp_valid_o(l_rd_rsp_valid),
    .l_wr_req_i(l_wr_req), .l_wr_req_valid_i(l_wr_req_valid),
    .l_wr_req_ready_o(l_wr_req_ready), .l_wr_rsp_valid_o(l_wr_rsp_valid),
    .rd_req_o(rd_req_o), .rd_req_valid_o(rd_req_valid_o), .rd_req_ready_i(rd_req_ready_i),
    .rd_rsp_i(rd_rsp_i), .rd_rsp_valid_i(rd_rsp_valid_i), .rd_rsp_ready_o(rd_rsp_ready_o),
    .wr_req_o(wr_req_o), .wr_req_valid_o(wr_req_valid_o), .wr_req_ready_i(wr_req_ready_i),
    .wr_rsp_i(wr_rsp_i), .wr_rsp_valid_i(wr_rsp_valid_i), .wr_rsp_ready_o(wr_rsp_ready_o)
  );

endmodule

//--- src/rv_bus_arbiter.sv
`timescale 1ns/1ns

module rv_bus_arbiter import rv_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  bus_rd_req_t f_rd_req_i,
  input  logic        f_rd_req_valid_i,
  output logic        f_rd_req_ready_o,
  output bus_rd_rsp_t f_rd_rsp_o,
  output logic        f_rd_rsp_valid_o,
  input  bus_rd_req_t l_rd_req_i,
  input  logic        l_rd_req_valid_i,
  output logic        l_rd_req_ready_o,
  output bus_rd_rsp_t l_rd_rsp_o,
  output logic        l_rd_rsp_valid_o,
  input  bus_wr_req_t l_wr_req_i,
  input  logic        l_wr_req_valid_i,
  output logic        l_wr_req_ready_o,
  output logic        l_wr_rsp_valid_o,
  output bus_rd_req_t rd_req_o,
  output logic        rd_req_valid_o,
  input  logic        rd_req_ready_i,
  input  bus_rd_rsp_t rd_rsp_i,
  input  logic        rd_rsp_valid_i,
  output logic        rd_rsp_ready_o,
  output bus_wr_req_t wr_req_o,
  output logic        wr_req_valid_o,
  input  logic        wr_req_ready_i,
  input  bus_wr_rsp_t wr_rsp_i,
  input  logic        wr_rsp_valid_i,
  output logic        wr_rsp_ready_o
);
  logic lock_q;
  logic gnt_lsu_q;
  logic gnt_lsu;

  // LSU wins a tie; the grant then holds until its response arrives
  assign gnt_lsu = lock_q ? gnt_lsu_q : l_rd_req_valid_i;

  assign rd_req_o         = gnt_lsu ? l_rd_req_i : f_rd_req_i;
  assign rd_req_valid_o   = gnt_lsu ? l_rd_req_valid_i : f_rd_req_valid_i;
  assign l_rd_req_ready_o = gnt_lsu && rd_req_ready_i;
  assign f_rd_req_ready_o = !gnt_lsu && rd_req_ready_i;

  assign rd_rsp_ready_o   = 1'b1;
  assign f_rd_rsp_o       = rd_rsp_i;
  assign l_rd_rsp_o       = rd_rsp_i;
  assign f_rd_rsp_valid_o = rd_rsp_valid_i && lock_q && !gnt_lsu_q;
  assign l_rd_rsp_valid_o = rd_rsp_valid_i && lock_q && gnt_lsu_q;

  // Only the LSU writes, and the response code carries no error path
  assign wr_req_o         = l_wr_req_i;
  assign wr_req_valid_o   = l_wr_req_valid_i;
  assign l_wr_req_ready_o = wr_req_ready_i;
  assign l_wr_rsp_valid_o = wr_rsp_valid_i;
  assign wr_rsp_ready_o   = 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      lock_q    <= 1'b0;
      gnt_lsu_q <= 1'b0;
    end else if (lock_q && rd_rsp_valid_i) begin
      lock_q <= 1'b0;
    end else if (!lock_q && (f_rd_req_valid_i || l_rd_req_valid_i)) begin
      lock_q    <= 1'b1;
      gnt_lsu_q <= l_rd_req_valid_i;
    end
  end

endmodule

//--- src/rv_lsu.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module rv_lsu import rv_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  mem_op_e          mem_op_i,
  input  logic [`XLEN-1:0] mem_addr_i,
  input  logic [`XLEN-1:0] mem_wdata_i,
  input  logic             mem_valid_i,
  output logic             mem_done_o,
  output logic [`XLEN-1:0] mem_rdata_o,
  output bus_rd_req_t      rd_req_o,
  output logic             rd_req_valid_o,
  input  logic             rd_req_ready_i,
  input  bus_rd_rsp_t      rd_rsp_i,
  input  logic             rd_rsp_valid_i,
  output bus_wr_req_t      wr_req_o,
  output logic             wr_req_valid_o,
  input  logic             wr_req_ready_i,
  input  logic             wr_rsp_valid_i
);
  typedef enum logic [2:0] {L_IDLE, L_RD_REQ, L_RD_WAIT, L_WR_REQ, L_WR_WAIT} state_e;

  state_e           state_q;
  logic [`XLEN-1:0] word_addr;
  logic             is_sb;

  // Execute holds the request fields until done, so they feed the bus directly
  assign word_addr = {mem_addr_i[`XLEN-1:2], 2'b00};
  assign is_sb     = (mem_op_i == MEM_SB);

  assign rd_req_o.addr  = word_addr;
  assign rd_req_valid_o = (state_q == L_RD_REQ);
  assign wr_req_o.addr  = word_addr;
  assign wr_req_o.data  = is_sb ? {4{mem_wdata_i[7:0]}} : mem_wdata_i;
  assign wr_req_o.strb  = is_sb ? (4'b0001 << mem_addr_i[1:0]) : 4'b1111;
  assign wr_req_valid_o = (state_q == L_WR_REQ);

  assign mem_done_o  = (state_q == L_RD_WAIT && rd_rsp_valid_i)
                    || (state_q == L_WR_WAIT && wr_rsp_valid_i);
  assign mem_rdata_o = rd_rsp_i.data;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= L_IDLE;
    end else begin
      case (state_q)
        L_IDLE: begin
          if (mem_valid_i && mem_op_i == MEM_LW) begin
            state_q <= L_RD_REQ;
          end else if (mem_valid_i && mem_op_i != MEM_NONE) begin
            state_q <= L_WR_REQ;
          end
        end
        L_RD_REQ:  if (rd_req_ready_i) state_q <= L_RD_WAIT;
        L_RD_WAIT: if (rd_rsp_valid_i) state_q <= L_IDLE;
        L_WR_REQ:  if (wr_req_ready_i) state_q <= L_WR_WAIT;
        L_WR_WAIT: if (wr_rsp_valid_i) state_q <= L_IDLE;
        default:   state_q <= L_IDLE;
      endcase
    end
  end

endmodule

//--- src/rv_execute.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module rv_execute import rv_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  exec_pkt_t        exec_i,
  input  logic             exec_valid_i,
  output logic             exec_ready_o,
  output mem_op_e          mem_op_o,
  output logic [`XLEN-1:0] mem_addr_o,
  output logic [`XLEN-1:0] mem_wdata_o,
  output logic             mem_valid_o,
  input  logic             mem_done_i,
  input  logic [`XLEN-1:0] mem_rdata_i,
  output logic             we_o,
  output logic [4:0]       rd_o,
  output logic [`XLEN-1:0] wdata_o,
  output logic             retire_o,
  output logic [`XLEN-1:0] next_pc_o,
  output logic             halt_o
);
  typedef enum logic [1:0] {X_IDLE, X_ALU, X_MEM} state_e;

  state_e           state_q;
  exec_pkt_t        pkt_q;
  logic             halt_q;
  logic             done, taken, is_jump;
  logic [`XLEN-1:0] alu_res, pc_plus4, target;

  always_comb begin
    case (pkt_q.alu_op)
      ALU_SUB:   alu_res = pkt_q.op_a - pkt_q.op_b;
      ALU_AND:   alu_res = pkt_q.op_a & pkt_q.op_b;
      ALU_OR:    alu_res = pkt_q.op_a | pkt_q.op_b;
      ALU_XOR:   alu_res = pkt_q.op_a ^ pkt_q.op_b;
      ALU_SLT:   alu_res = {31'b0, $signed(pkt_q.op_a) < $signed(pkt_q.op_b)};
      ALU_PASSB: alu_res = pkt_q.op_b;
      default:   alu_res = pkt_q.op_a + pkt_q.op_b;
    endcase
  end

  assign is_jump  = (pkt_q.br_kind == BR_JAL) || (pkt_q.br_kind == BR_JALR);
  assign taken    = is_jump
                 || (pkt_q.br_kind == BR_BEQ && pkt_q.op_a == pkt_q.op_b)
                 || (pkt_q.br_kind == BR_BNE && pkt_q.op_a != pkt_q.op_b);
  assign pc_plus4 = pkt_q.pc + 32'd4;
  // jalr targets rs1 plus offset with bit 0 cleared
  assign target   = (pkt_q.br_kind == BR_JALR) ? ((pkt_q.op_a + pkt_q.imm) & ~32'd1)
                                               : (pkt_q.pc + pkt_q.imm);

  assign done      = (state_q == X_ALU) || (state_q == X_MEM && mem_done_i);
  assign retire_o  = done && !pkt_q.halt;
  assign we_o      = done && pkt_q.rd_we;
  assign rd_o      = pkt_q.rd;
  assign wdata_o   = is_jump ? pc_plus4 : (pkt_q.mem_op == MEM_LW) ? mem_rdata_i : alu_res;
  assign next_pc_o = taken ? target : pc_plus4;
  assign halt_o    = halt_q;

  assign exec_ready_o = (state_q == X_IDLE);
  assign mem_valid_o  = (state_q == X_MEM);
  assign mem_op_o     = pkt_q.mem_op;
  assign mem_addr_o   = pkt_q.op_a + pkt_q.imm;
  assign mem_wdata_o  = pkt_q.op_b;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= X_IDLE;
      halt_q  <= 1'b0;
    end else begin
      if (done && pkt_q.halt) begin
        halt_q <= 1'b1;
      end
      case (state_q)
        X_IDLE: begin
          if (exec_valid_i) begin
            state_q <= (exec_i.mem_op == MEM_NONE) ? X_ALU : X_MEM;
          end
        end
        X_MEM:   if (mem_done_i) state_q <= X_IDLE;
        default: state_q <= X_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (exec_valid_i && exec_ready_o) begin
      pkt_q <= exec_i;
    end
  end

endmodule

//--- src/rv_regfile.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  logic [4:0]       rs1_i,
  input  logic [4:0]       rs2_i,
  output logic [`XLEN-1:0] rs1_data_o,
  output logic [`XLEN-1:0] rs2_data_o,
  input  logic             we_i,
  input  logic [4:0]       rd_i,
  input  logic [`XLEN-1:0] wdata_i
);
  logic [`XLEN-1:0] regs_q [`RV_NREGS];

  assign rs1_data_o = regs_q[rs1_i];
  assign rs2_data_o = regs_q[rs2_i];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && rd_i != 5'd0) begin
      // x0 stays zero
      regs_q[rd_i] <= wdata_i;
    end
  end

endmodule

//--- src/rv_decode.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module rv_decode import rv_pkg::*; (
  input  fetch_pkt_t       pkt_i,
  input  logic             pkt_valid_i,
  output logic             pkt_ready_o,
  output logic [4:0]       rs1_o,
  output logic [4:0]       rs2_o,
  input  logic [`XLEN-1:0] rs1_data_i,
  input  logic [`XLEN-1:0] rs2_data_i,
  output exec_pkt_t        exec_o,
  output logic             exec_valid_o,
  input  logic             exec_ready_i
);
  logic [31:0] instr;
  logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;

  assign instr  = pkt_i.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1_o  = instr[19:15];
  assign rs2_o  = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // Decode is pure logic so both handshakes pass straight through
  assign pkt_ready_o  = exec_ready_i;
  assign exec_valid_o = pkt_valid_i;

  always_comb begin
    exec_o         = '0;
    exec_o.pc      = pkt_i.pc;
    exec_o.op_a    = rs1_data_i;
    exec_o.op_b    = rs2_data_i;
    exec_o.imm     = imm_i;
    exec_o.rd      = instr[11:7];
    exec_o.alu_op  = ALU_ADD;
    exec_o.mem_op  = MEM_NONE;
    exec_o.br_kind = BR_NONE;
    case (opcode)
      7'b0110111: begin
        exec_o.op_b   = imm_u;
        exec_o.alu_op = ALU_PASSB;
        exec_o.rd_we  = 1'b1;
      end
      7'b0010111: begin
        exec_o.op_a  = pkt_i.pc;
        exec_o.op_b  = imm_u;
        exec_o.rd_we = 1'b1;
      end
      7'b1101111: begin
        exec_o.imm     = imm_j;
        exec_o.br_kind = BR_JAL;
        exec_o.rd_we   = 1'b1;
      end
      7'b1100111: begin
        exec_o.br_kind = BR_JALR;
        exec_o.rd_we   = 1'b1;
        exec_o.halt    = (funct3 != 3'b000);
      end
      7'b1100011: begin
        exec_o.imm = imm_b;
        case (funct3)
          3'b000:  exec_o.br_kind = BR_BEQ;
          3'b001:  exec_o.br_kind = BR_BNE;
          default: exec_o.halt = 1'b1;
        endcase
      end
      7'b0010011: begin
        exec_o.op_b  = imm_i;
        exec_o.rd_we = (funct3 == 3'b000);
        exec_o.halt  = (funct3 != 3'b000);
      end
      7'b0110011: begin
        exec_o.rd_we = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: exec_o.alu_op = ALU_ADD;
          10'b0100000_000: exec_o.alu_op = ALU_SUB;
          10'b0000000_111: exec_o.alu_op = ALU_AND;
          10'b0000000_110: exec_o.alu_op = ALU_OR;
          10'b0000000_100: exec_o.alu_op = ALU_XOR;
          10'b0000000_010: exec_o.alu_op = ALU_SLT;
          default: begin
            exec_o.rd_we = 1'b0;
            exec_o.halt  = 1'b1;
          end
        endcase
      end
      7'b0000011: begin
        exec_o.mem_op = MEM_LW;
        exec_o.rd_we  = (funct3 == 3'b010);
        exec_o.halt   = (funct3 != 3'b010);
      end
      7'b0100011: begin
        exec_o.imm = imm_s;
        case (funct3)
          3'b010:  exec_o.mem_op = MEM_SW;
          3'b000:  exec_o.mem_op = MEM_SB;
          default: exec_o.halt = 1'b1;
        endcase
      end
      // ebreak and everything unsupported stop the core
      default: exec_o.halt = 1'b1;
    endcase
    if (exec_o.halt) begin
      exec_o.mem_op = MEM_NONE;
    end
  end

endmodule

//--- src/rv_stage_reg.sv
`timescale 1ns/1ns

module rv_stage_reg #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst,
  input  T     in_i,
  input  logic in_valid_i,
  output logic in_ready_o,
  output T     out_o,
  output logic out_valid_o,
  input  logic out_ready_i
);
  T     data_q;
  logic valid_q;

  // Refills in the same cycle the held entry leaves
  assign in_ready_o  = !valid_q || out_ready_i;
  assign out_o       = data_q;
  assign out_valid_o = valid_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (in_valid_i && in_ready_o) begin
      valid_q <= 1'b1;
    end else if (out_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_i;
    end
  end

endmodule

//--- src/rv_fetch.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module rv_fetch import rv_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic             retire_i,
  input  logic [`XLEN-1:0] next_pc_i,
  input  logic             halt_i,
  output bus_rd_req_t      rd_req_o,
  output logic             rd_req_valid_o,
  input  logic             rd_req_ready_i,
  input  bus_rd_rsp_t      rd_rsp_i,
  input  logic             rd_rsp_valid_i,
  output fetch_pkt_t       pkt_o,
  output logic             pkt_valid_o,
  input  logic             pkt_ready_i
);
  typedef enum logic [1:0] {F_IDLE, F_REQ, F_WAIT, F_PRESENT} state_e;

  state_e           state_q;
  logic             start_q;
  logic [`XLEN-1:0] pc_q;
  logic [31:0]      instr_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= F_IDLE;
      start_q <= 1'b1;
      pc_q    <= `RV_PC_RESET;
    end else begin
      if (retire_i) begin
        pc_q <= next_pc_i;
      end
      case (state_q)
        // First fetch after reset, then one per retired instruction
        F_IDLE: begin
          if ((start_q || retire_i) && !halt_i) begin
            state_q <= F_REQ;
            start_q <= 1'b0;
          end
        end
        F_REQ:     if (rd_req_ready_i) state_q <= F_WAIT;
        F_WAIT:    if (rd_rsp_valid_i) state_q <= F_PRESENT;
        F_PRESENT: if (pkt_ready_i) state_q <= F_IDLE;
        default:   state_q <= F_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == F_WAIT && rd_rsp_valid_i) begin
      instr_q <= rd_rsp_i.data;
    end
  end

  assign rd_req_o.addr  = pc_q;
  assign rd_req_valid_o = (state_q == F_REQ);
  assign pkt_o.pc       = pc_q;
  assign pkt_o.instr    = instr_q;
  assign pkt_valid_o    = (state_q == F_PRESENT);

endmodule

//--- src/rv_pkg.sv
`include "rv_macros.svh"

package rv_pkg;

  typedef enum logic [3:0] {
    ALU_ADD   = 4'd0,
    ALU_SUB   = 4'd1,
    ALU_AND   = 4'd2,
    ALU_OR    = 4'd3,
    ALU_XOR   = 4'd4,
    ALU_SLT   = 4'd5,
    ALU_PASSB = 4'd6
  } alu_op_e;

  typedef enum logic [1:0] {
    MEM_NONE = 2'd0,
    MEM_LW   = 2'd1,
    MEM_SW   = 2'd2,
    MEM_SB   = 2'd3
  } mem_op_e;

  typedef enum logic [2:0] {
    BR_NONE = 3'd0,
    BR_BEQ  = 3'd1,
    BR_BNE  = 3'd2,
    BR_JAL  = 3'd3,
    BR_JALR = 3'd4
  } br_kind_e;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [31:0]      instr;
  } fetch_pkt_t;

  // Operands are already selected by decode
  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] imm;
    logic [4:0]       rd;
    logic             rd_we;
    alu_op_e          alu_op;
    mem_op_e          mem_op;
    br_kind_e         br_kind;
    logic             halt;
  } exec_pkt_t;

  typedef struct packed {
    logic [`XLEN-1:0] addr;
  } bus_rd_req_t;

  typedef struct packed {
    logic [`XLEN-1:0] data;
    logic [1:0]       resp;
  } bus_rd_rsp_t;

  typedef struct packed {
    logic [`XLEN-1:0]   addr;
    logic [`XLEN-1:0]   data;
    logic [`XLEN/8-1:0] strb;
  } bus_wr_req_t;

  typedef struct packed {
    logic [1:0] resp;
  } bus_wr_rsp_t;

endpackage

//--- src/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Word width of the datapath and the bus
`define XLEN 32

// Architectural register count
`define RV_NREGS 32

// First fetch address
`define RV_PC_RESET 32'h0000_0000

`endif
